// File: rtl/grid_pkg.sv
package grid_pkg;

    localparam int grid_width  = 16;  // columns of the playfield
    localparam int grid_height = 12;  // rows of the playfield

    localparam int coord_w = 4;  // wide enough for the larger of the two sizes
    localparam int code_w  = 3;

    // object codes as the tile renderer expects them
    typedef enum logic [code_w-1:0] {
        blank      = 3'd0,
        snake_head = 3'd1,
        snake_body = 3'd2,
        apple_c    = 3'd3,
        border_c   = 3'd4
    } obj_code_t;

endpackage

// File: rtl/draw_pkg.sv
package draw_pkg;

    // one queued command is {x, y, code}
    localparam int draw_cmd_w = 2 * grid_pkg::coord_w + grid_pkg::code_w;

    localparam int default_fifo_depth = 8;  // must be a power of two

endpackage

// File: rtl/scene_board.sv
`timescale 1ns/1ps

module scene_board (
    input  logic                         clk,
    input  logic                         nrst,
    input  logic                         wr_valid,
    output logic                         wr_ready,
    input  logic [grid_pkg::coord_w-1:0] wr_x,
    input  logic [grid_pkg::coord_w-1:0] wr_y,
    input  grid_pkg::obj_code_t          wr_code,
    input  logic [grid_pkg::coord_w-1:0] rd_x,
    input  logic [grid_pkg::coord_w-1:0] rd_y,
    output logic                         body,
    output logic                         head,
    output logic                         apple,
    output logic                         border
);

    import grid_pkg::*;

    obj_code_t board [grid_width][grid_height];  // wanted code per cell
    obj_code_t rd_code;
    logic      wr_take;
    logic      wr_in_grid;

    assign wr_ready = 1'b1;  // the board can take a write on every cycle

    assign wr_in_grid = (wr_x < grid_width) && (wr_y < grid_height);
    assign wr_take    = wr_valid && wr_ready && wr_in_grid;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < grid_width; i++) begin
                for (int j = 0; j < grid_height; j++) begin
                    board[i][j] <= blank;
                end
            end
        end else if (wr_take) begin
            board[wr_x][wr_y] <= wr_code;  // seen by the scan from the next cycle
        end
    end

    assign rd_code = board[rd_x][rd_y];

    always_comb begin
        body   = 1'b0;
        head   = 1'b0;
        apple  = 1'b0;
        border = 1'b0;
        case (rd_code)
            snake_body: body   = 1'b1;
            snake_head: head   = 1'b1;
            apple_c:    apple  = 1'b1;
            border_c:   border = 1'b1;
            default:    ;  // blank raises no flag
        endcase
    end

    // the host must only address cells that exist
    a_wr_in_grid: assert property (
        @(posedge clk) disable iff (!nrst)
        (wr_valid && wr_ready) |-> wr_in_grid
    ) else $error("scene_board: write outside the grid at x=%0d y=%0d", wr_x, wr_y);

endmodule

// File: rtl/frame_tracker.sv
`timescale 1ns/1ps

module frame_tracker (
    input  logic                         clk,
    input  logic                         nrst,
    input  logic                         enable,
    input  logic                         body,
    input  logic                         head,
    input  logic                         apple,
    input  logic                         border,
    output grid_pkg::obj_code_t          obj_code,
    output logic [grid_pkg::coord_w-1:0] x,
    output logic [grid_pkg::coord_w-1:0] y,
    output logic                         diff
);

    import grid_pkg::*;

    localparam logic [coord_w-1:0] last_x = coord_w'(grid_width - 1);
    localparam logic [coord_w-1:0] last_y = coord_w'(grid_height - 1);

    obj_code_t          frame [grid_width][grid_height];  // what the renderer already shows
    logic [coord_w-1:0] cur_x;
    logic [coord_w-1:0] cur_y;
    obj_code_t          drawn;
    obj_code_t          wanted;
    logic               on_edge;

    // scan counter, row-major with x fastest
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            cur_x <= '0;
            cur_y <= '0;
        end else if (enable) begin
            if (cur_x == last_x) begin
                cur_x <= '0;
                cur_y <= (cur_y == last_y) ? '0 : cur_y + 1'b1;
            end else begin
                cur_x <= cur_x + 1'b1;
            end
        end
    end

    assign drawn   = frame[cur_x][cur_y];
    assign on_edge = (cur_x == '0) || (cur_x == last_x) || (cur_y == '0) || (cur_y == last_y);

    // turn the flags back into a code
    always_comb begin
        if (head) begin
            wanted = snake_head;
        end else if (body) begin
            wanted = snake_body;
        end else if (apple) begin
            wanted = apple_c;
        end else if (border) begin
            wanted = border_c;
        end else begin
            wanted = blank;
        end
    end

    always_comb begin
        if (on_edge) begin
            diff = border && (drawn != border_c);  // edges only ever become border
        end else begin
            diff = !border && (wanted != drawn);  // border is ignored inside the field
        end
        obj_code = diff ? wanted : drawn;
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < grid_width; i++) begin
                for (int j = 0; j < grid_height; j++) begin
                    frame[i][j] <= blank;
                end
            end
        end else if (enable && diff) begin
            frame[cur_x][cur_y] <= obj_code;  // the command for this cell is queued now
        end
    end

    assign x = cur_x;
    assign y = cur_y;

    a_scan_in_grid: assert property (
        @(posedge clk) disable iff (!nrst)
        (cur_x < grid_width) && (cur_y < grid_height)
    ) else $error("frame_tracker: scan left the grid at x=%0d y=%0d", cur_x, cur_y);

    // the board decodes one code per cell, so its flags never overlap
    a_flags_onehot: assert property (
        @(posedge clk) disable iff (!nrst)
        $onehot0({body, head, apple, border})
    ) else $error("frame_tracker: more than one object flag at x=%0d y=%0d", cur_x, cur_y);

endmodule

// File: rtl/draw_fifo.sv
`timescale 1ns/1ps

module draw_fifo #(
    parameter int fifo_depth = draw_pkg::default_fifo_depth
) (
    input  logic                         clk,
    input  logic                         nrst,
    input  logic                         push,
    input  logic [grid_pkg::coord_w-1:0] push_x,
    input  logic [grid_pkg::coord_w-1:0] push_y,
    input  grid_pkg::obj_code_t          push_code,
    output logic                         room,
    output logic                         draw_valid,
    input  logic                         draw_ready,
    output logic [grid_pkg::coord_w-1:0] draw_x,
    output logic [grid_pkg::coord_w-1:0] draw_y,
    output grid_pkg::obj_code_t          draw_code
);

    import grid_pkg::*;
    import draw_pkg::*;

    localparam int ptr_w = $clog2(fifo_depth);

    logic [draw_cmd_w-1:0] mem [fifo_depth];
    logic [ptr_w-1:0]      wr_ptr;
    logic [ptr_w-1:0]      rd_ptr;
    logic [ptr_w:0]        count;
    logic [draw_cmd_w-1:0] head_cmd;
    logic                  pop;

    assign room       = (count != (ptr_w + 1)'(fifo_depth));
    assign draw_valid = (count != '0);
    assign pop        = draw_valid && draw_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {push_x, push_y, push_code};
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // both or neither leave the level unchanged
            endcase
        end
    end

    assign head_cmd  = mem[rd_ptr];  // stays put until it is taken
    assign draw_x    = head_cmd[draw_cmd_w-1 -: coord_w];
    assign draw_y    = head_cmd[code_w +: coord_w];
    assign draw_code = obj_code_t'(head_cmd[code_w-1:0]);

    // the tracker must stall on a full queue
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!nrst)
        push |-> room
    ) else $error("draw_fifo: push while full");

endmodule

// File: rtl/snake_display.sv
`timescale 1ns/1ps

module snake_display #(
    parameter int fifo_depth = draw_pkg::default_fifo_depth
) (
    input  logic                         clk,
    input  logic                         nrst,
    input  logic                         wr_valid,
    output logic                         wr_ready,
    input  logic [grid_pkg::coord_w-1:0] wr_x,
    input  logic [grid_pkg::coord_w-1:0] wr_y,
    input  grid_pkg::obj_code_t          wr_code,
    output logic                         draw_valid,
    input  logic                         draw_ready,
    output logic [grid_pkg::coord_w-1:0] draw_x,
    output logic [grid_pkg::coord_w-1:0] draw_y,
    output grid_pkg::obj_code_t          draw_code
);

    import grid_pkg::*;

    logic [coord_w-1:0] scan_x;
    logic [coord_w-1:0] scan_y;
    logic               body;
    logic               head;
    logic               apple;
    logic               border;
    obj_code_t          obj_code;
    logic               diff;
    logic               room;
    logic               push;

    scene_board i_board (
        .clk      (clk),
        .nrst     (nrst),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .wr_x     (wr_x),
        .wr_y     (wr_y),
        .wr_code  (wr_code),
        .rd_x     (scan_x),
        .rd_y     (scan_y),
        .body     (body),
        .head     (head),
        .apple    (apple),
        .border   (border)
    );

    frame_tracker i_tracker (
        .clk      (clk),
        .nrst     (nrst),
        .enable   (room),  // scan freezes while the queue is full
        .body     (body),
        .head     (head),
        .apple    (apple),
        .border   (border),
        .obj_code (obj_code),
        .x        (scan_x),
        .y        (scan_y),
        .diff     (diff)
    );

    assign push = diff && room;

    draw_fifo #(
        .fifo_depth (fifo_depth)
    ) i_fifo (
        .clk        (clk),
        .nrst       (nrst),
        .push       (push),
        .push_x     (scan_x),
        .push_y     (scan_y),
        .push_code  (obj_code),
        .room       (room),
        .draw_valid (draw_valid),
        .draw_ready (draw_ready),
        .draw_x     (draw_x),
        .draw_y     (draw_y),
        .draw_code  (draw_code)
    );

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int period_ns = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

endmodule

// File: verif/tb_snake_display.sv
`timescale 1ns/1ps

module tb_snake_display;

    import grid_pkg::*;

    typedef logic [coord_w-1:0] coordinate;

    localparam int sweep_cycles = grid_width * grid_height;
    localparam int quiet_cycles = sweep_cycles + 40;  // a sweep plus room for a long stall
    localparam int max_lines    = 128;

    logic      clk;
    logic      nrst;
    logic      wr_valid;
    logic      wr_ready;
    coordinate wr_x;
    coordinate wr_y;
    obj_code_t wr_code;
    logic      draw_valid;
    logic      draw_ready;
    coordinate draw_x;
    coordinate draw_y;
    obj_code_t draw_code;

    logic [15:0] lines [max_lines];
    obj_code_t   wanted [grid_width][grid_height];  // what the host asked for
    obj_code_t   model [grid_width][grid_height];   // what the renderer has been told
    int          cmds_seen;
    int          expected_cmds;
    int          cycle_count;
    int          cycle_limit;
    int          stall_left;
    coordinate   last_x;
    coordinate   last_y;
    obj_code_t   last_code;

    tb_clk_gen #(
        .period_ns (20)
    ) i_clk_gen (
        .clk (clk)
    );

    snake_display #(
        .fifo_depth (draw_pkg::default_fifo_depth)
    ) i_dut (
        .clk        (clk),
        .nrst       (nrst),
        .wr_valid   (wr_valid),
        .wr_ready   (wr_ready),
        .wr_x       (wr_x),
        .wr_y       (wr_y),
        .wr_code    (wr_code),
        .draw_valid (draw_valid),
        .draw_ready (draw_ready),
        .draw_x     (draw_x),
        .draw_y     (draw_y),
        .draw_code  (draw_code)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_code(input string name, input obj_code_t got, input obj_code_t exp);
        if (got !== exp) begin
            fail_run($sformatf("error %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_coord(input string name, input coordinate got, input coordinate exp);
        if (got !== exp) begin
            fail_run($sformatf("error %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("error %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // edges only take border while the interior takes anything but border
    function automatic logic change_due(input coordinate cx, input coordinate cy,
                                        input obj_code_t want, input obj_code_t shown);
        logic on_edge;
        on_edge = (cx == 0) || (cx == grid_width - 1) || (cy == 0) || (cy == grid_height - 1);
        if (on_edge) begin
            return (want == border_c) && (shown != border_c);
        end
        return (want != border_c) && (want != shown);
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic write_cell(input coordinate cx, input coordinate cy, input obj_code_t code,
                              output logic due);
        wr_valid = 1'b1;
        wr_x     = cx;
        wr_y     = cy;
        wr_code  = code;
        do begin
            @(posedge clk);
        end while (!wr_ready);
        #1;
        wr_valid = 1'b0;
        due = change_due(cx, cy, code, model[cx][cy]);
        if (due) begin
            expected_cmds++;
        end
        wanted[cx][cy] = code;  // updated after the edge so the monitor still sees the old code
    endtask

    task automatic settle();
        while (cmds_seen < expected_cmds) begin
            @(posedge clk);
            #1;
        end
        idle_cycles(quiet_cycles);
        if (cmds_seen != expected_cmds) begin
            fail_run($sformatf("saw %0d draw commands where %0d were due",
                               cmds_seen, expected_cmds));
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            fail_run($sformatf("timeout: the run did not finish within %0d cycles", cycle_limit));
        end
    end

    // the draw port stalls at random and sometimes for long
    always @(posedge clk) begin
        #1;
        if (stall_left > 0) begin
            draw_ready = 1'b0;
            stall_left--;
        end else if ($urandom % 4 == 0) begin
            draw_ready = 1'b0;
            stall_left = $urandom % 32;
        end else begin
            draw_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (nrst && draw_valid && draw_ready) begin
            if (draw_x >= grid_width || draw_y >= grid_height) begin
                fail_run($sformatf("draw command outside the grid at x=%0d y=%0d",
                                   draw_x, draw_y));
            end else if (!change_due(draw_x, draw_y, wanted[draw_x][draw_y],
                                     model[draw_x][draw_y])) begin
                fail_run($sformatf("draw command at x=%0d y=%0d where nothing had changed",
                                   draw_x, draw_y));
            end else begin
                check_code("draw_code", draw_code, wanted[draw_x][draw_y]);
                model[draw_x][draw_y] = draw_code;
                last_x    = draw_x;
                last_y    = draw_y;
                last_code = draw_code;
                cmds_seen++;
            end
        end
    end

    initial begin
        int          n_writes;
        int          idx;
        logic [3:0]  kind;
        coordinate   lx;
        coordinate   ly;
        obj_code_t   lcode;
        logic        due;
        obj_code_t   exp_frame [grid_width][grid_height];

        void'($urandom(32'h1229_aa20));
        nrst          = 1'b0;
        wr_valid      = 1'b0;
        wr_x          = '0;
        wr_y          = '0;
        wr_code       = blank;
        draw_ready    = 1'b0;
        cmds_seen     = 0;
        expected_cmds = 0;
        cycle_count   = 0;
        cycle_limit   = 0;
        stall_left    = 0;
        last_x        = '0;
        last_y        = '0;
        last_code     = blank;
        for (int i = 0; i < grid_width; i++) begin
            for (int j = 0; j < grid_height; j++) begin
                wanted[i][j]    = blank;
                model[i][j]     = blank;
                exp_frame[i][j] = blank;
            end
        end
        for (int i = 0; i < max_lines; i++) begin
            lines[i] = '0;
        end
        $readmemh("verif/scene_input.txt", lines);

        n_writes = 0;
        for (int i = 0; i < max_lines; i++) begin
            if (lines[i][15:12] == 4'h1 || lines[i][15:12] == 4'h2) begin
                n_writes++;
            end
        end
        cycle_limit = 2000 + 400 * n_writes;

        repeat (10) @(posedge clk);
        #1;
        nrst = 1'b1;

        // nothing written yet so a full sweep must stay silent
        repeat (sweep_cycles + 8) begin
            @(posedge clk);
            #1;
            check_flag("draw_valid", draw_valid, 1'b0);
            check_flag("wr_ready", wr_ready, 1'b1);
        end

        idx = 0;
        while (idx < max_lines && lines[idx][15:12] != 4'h0) begin
            kind  = lines[idx][15:12];
            lx    = lines[idx][11:8];
            ly    = lines[idx][7:4];
            lcode = obj_code_t'(lines[idx][2:0]);
            case (kind)
                4'h1: begin
                    idle_cycles($urandom % 8);
                    write_cell(lx, ly, lcode, due);
                    settle();
                    if (due) begin
                        check_coord("draw_x", last_x, lx);
                        check_coord("draw_y", last_y, ly);
                        check_code("draw_code", last_code, lcode);
                    end
                end
                4'h2: begin
                    idle_cycles($urandom % 3);  // the queue may fill during a burst
                    write_cell(lx, ly, lcode, due);
                end
                4'hd, 4'he: begin
                    settle();
                end
                4'h3: begin
                    exp_frame[lx][ly] = lcode;
                end
                default: begin
                    fail_run($sformatf("unknown line %h in the data file", lines[idx]));
                end
            endcase
            idx++;
        end

        for (int i = 0; i < grid_width; i++) begin
            for (int j = 0; j < grid_height; j++) begin
                check_code($sformatf("frame[%0d][%0d]", i, j), model[i][j], exp_frame[i][j]);
            end
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: snake_display.f
rtl/grid_pkg.sv
rtl/draw_pkg.sv
rtl/scene_board.sv
rtl/frame_tracker.sv
rtl/draw_fifo.sv
rtl/snake_display.sv
verif/tb_clk_gen.sv
verif/tb_snake_display.sv

// File: verif/scene_input.txt
// one hex word per line: kind, x, y, code (0 blank 1 head 2 body 3 apple 4 border)
// kind 1 write and settle, 2 burst write, d settle, e settle then 3 expected final cells
1552 // body in the interior
1652
1751 // head
1a83 // apple
1652 // same code again, no command
1550 // blank over a drawn body
1550
1004 // corner border
1f34
17b4
1092 // body on an edge is ignored
1884 // border inside is ignored
1f34
1a81 // head replaces the apple
2112
2212
2312
2412
2512
2611
2712
2812
2912
2a23
2ea4 // interior border inside a burst
20a4
2e04
2b73
2c72
2d72
22a2
2350 // blank over blank
d000
1511 // head over a burst cell
e000
3652
3751
3a81
3004
3f34
37b4
3112
3212
3312
3412
3511
3611
3712
3812
3912
3a23
30a4
3e04
3b73
3c72
3d72
32a2
